//--- common/pc_pkg.sv
`default_nettype none

package pc_pkg;

   // datapath and register file geometry
   localparam int unsigned xlen       = 64;
   localparam int unsigned reg_count  = 32;
   localparam int unsigned reg_addr_w = $clog2(reg_count);

   localparam logic [xlen-1:0] reset_vector = 64'h0000_0000_8000_0000; // also ebreak target
   localparam logic [xlen-1:0] pc_step      = 64'd4;

   // branch comparisons, same codes as funct3
   typedef enum logic [2:0] {
      cmp_eq  = 3'd0,
      cmp_ne  = 3'd1,
      cmp_lt  = 3'd4,
      cmp_ge  = 3'd5,
      cmp_ltu = 3'd6,
      cmp_geu = 3'd7
   } cmp_op_e;

   // decoded control for the next-pc logic
   typedef struct packed {
      logic    branch;
      logic    jump;
      logic    jalr;    // valid with jump
      logic    ebreak;
      cmp_op_e cmp_op;  // valid with branch
   } pc_ctrl_t;

endpackage

`default_nettype wire

//--- hw/branch_cmp.sv
`timescale 1ns/1ps
`default_nettype none

module branch_cmp
   import pc_pkg::*;
(
   input  wire logic [xlen-1:0] a,
   input  wire logic [xlen-1:0] b,
   input  wire cmp_op_e         op,
   output logic                 cond
);

   logic is_eq;
   logic is_lt;
   logic is_ltu;

   assign is_eq  = (a == b);
   assign is_lt  = ($signed(a) < $signed(b));
   assign is_ltu = (a < b);

   always_comb begin
      case (op)
         cmp_eq: begin
            cond = is_eq;
         end
         cmp_ne: begin
            cond = !is_eq;
         end
         cmp_lt: begin
            cond = is_lt;
         end
         cmp_ge: begin
            cond = !is_lt;
         end
         cmp_ltu: begin
            cond = is_ltu;
         end
         cmp_geu: begin
            cond = !is_ltu;
         end
         default: begin
            cond = 1'b0; // codes 2 and 3
         end
      endcase
   end

   // comparison code comes straight from decode
   always_comb begin
      assert final (!$isunknown(op))
         else $error("branch_cmp: op is unknown");
   end

endmodule

`default_nettype wire

//--- hw/next_pc_sel.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_sel
   import pc_pkg::*;
(
   input  wire logic            clk,
   input  wire logic            rst_n,
   input  wire pc_ctrl_t        ctrl,
   input  wire logic [xlen-1:0] imm,
   input  wire logic [xlen-1:0] curr_pc,
   input  wire logic            cond,
   input  wire logic [xlen-1:0] rs1_data,
   input  wire logic            ld_hazard,
   input  wire logic [xlen-1:0] fwd_data,
   output logic      [xlen-1:0] next_pc,
   output logic                 redirect,
   output logic                 jalr_stall,
   output logic                 pc_load
);

   logic            jalr_pend;  // jalr waiting on load data
   logic [xlen-1:0] seq_pc;
   logic [xlen-1:0] rel_pc;
   logic [xlen-1:0] jalr_sum;
   logic [xlen-1:0] fwd_sum;

   assign seq_pc   = curr_pc + pc_step;
   assign rel_pc   = curr_pc + imm;
   assign jalr_sum = rs1_data + imm;
   assign fwd_sum  = fwd_data + imm;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         jalr_pend <= 1'b0;
      end else begin
         jalr_pend <= jalr_stall;
      end
   end

   always_comb begin
      next_pc    = seq_pc;
      redirect   = 1'b0;
      jalr_stall = 1'b0;
      pc_load    = 1'b1;
      if (ctrl.branch) begin
         if (cond) begin
            next_pc  = rel_pc; // taken
            redirect = 1'b1;
         end
      end else if (ctrl.jump && !ctrl.jalr) begin
         next_pc  = rel_pc; // jal
         redirect = 1'b1;
      end else if (ctrl.jump && ctrl.jalr) begin
         if (ld_hazard) begin
            next_pc    = curr_pc;
            jalr_stall = 1'b1; // base not ready yet
            pc_load    = 1'b0;
         end else begin
            next_pc  = {jalr_sum[xlen-1:1], 1'b0};
            redirect = 1'b1;
         end
      end else if (jalr_pend) begin
         next_pc  = {fwd_sum[xlen-1:1], 1'b0}; // base from load
         redirect = 1'b1;
      end else if (ctrl.ebreak) begin
         next_pc  = reset_vector;
         redirect = 1'b1;
      end
   end

   // a stalled jalr must finish on the next cycle
   a_no_double_stall: assert property (@(posedge clk) disable iff (!rst_n)
      jalr_stall |=> !jalr_stall)
      else $error("next_pc_sel: jalr_stall on consecutive cycles");

   a_stall_is_jalr: assert property (@(posedge clk) disable iff (!rst_n)
      jalr_stall |-> (ctrl.jump && ctrl.jalr))
      else $error("next_pc_sel: jalr_stall without jalr");

   // caller keeps control quiet while the delayed jalr completes
   a_quiet_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
      jalr_stall |=> !(ctrl.branch || ctrl.jump || ctrl.jalr || ctrl.ebreak))
      else $error("next_pc_sel: new control in the cycle after a stall");

endmodule

`default_nettype wire

//--- hw/pc_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pc_reg
   import pc_pkg::*;
(
   input  wire logic            clk,
   input  wire logic            rst_n,
   input  wire logic            ena,
   input  wire logic            load,
   input  wire logic [xlen-1:0] next_pc,
   output logic      [xlen-1:0] pc
);

   logic upd;

   // ena low freezes fetch, load low holds during a stall
   assign upd = ena && load;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= reset_vector;
      end else if (upd) begin
         pc <= next_pc;
      end
   end

   // every target upstream is kept halfword aligned
   a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      !pc[0])
      else $error("pc_reg: pc bit 0 set, pc = %h", pc);

endmodule

`default_nettype wire

//--- hw/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_file
   import pc_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic [reg_addr_w-1:0] rs1,
   input  wire logic [reg_addr_w-1:0] rs2,
   output logic      [xlen-1:0]       rs1_data,
   output logic      [xlen-1:0]       rs2_data,
   input  wire logic                  wr_en,
   input  wire logic [reg_addr_w-1:0] wr_addr,
   input  wire logic [xlen-1:0]       wr_data
);

   logic [xlen-1:0] regs [reg_count];
   logic            wr_ok;

   assign wr_ok = wr_en && (wr_addr != '0); // x0 is read only

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_ok) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // no bypass, a same-cycle write shows up next cycle
   assign rs1_data = regs[rs1];
   assign rs2_data = regs[rs2];

   a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (rs1 == '0) |-> (rs1_data == '0))
      else $error("gpr_file: x0 read back %h", rs1_data);

endmodule

`default_nettype wire

//--- hw/pc_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit_top
   import pc_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic                  ena,
   input  wire pc_ctrl_t              ctrl,
   input  wire logic [xlen-1:0]       imm,
   input  wire logic [reg_addr_w-1:0] rs1,
   input  wire logic [reg_addr_w-1:0] rs2,
   input  wire logic                  ld_hazard,
   input  wire logic [xlen-1:0]       fwd_data,
   input  wire logic                  wr_en,
   input  wire logic [reg_addr_w-1:0] wr_addr,
   input  wire logic [xlen-1:0]       wr_data,
   output logic      [xlen-1:0]       pc,
   output logic                       jalr_stall,
   output logic                       redirect
);

   logic [xlen-1:0] rs1_data;
   logic [xlen-1:0] rs2_data;
   logic            cond;
   logic [xlen-1:0] next_pc;
   logic            pc_load;

   gpr_file gpr_file_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (rs1),
      .rs2      (rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   branch_cmp branch_cmp_i (
      .a    (rs1_data),
      .b    (rs2_data),
      .op   (ctrl.cmp_op),
      .cond (cond)
   );

   next_pc_sel next_pc_sel_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .ctrl       (ctrl),
      .imm        (imm),
      .curr_pc    (pc),
      .cond       (cond),
      .rs1_data   (rs1_data), // jalr base
      .ld_hazard  (ld_hazard),
      .fwd_data   (fwd_data),
      .next_pc    (next_pc),
      .redirect   (redirect),
      .jalr_stall (jalr_stall),
      .pc_load    (pc_load)
   );

   pc_reg pc_reg_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .ena     (ena),
      .load    (pc_load),
      .next_pc (next_pc),
      .pc      (pc)
   );

endmodule

`default_nettype wire

//--- verif/tb_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pc_unit
   import pc_pkg::*;
();

   localparam int max_cycles = 3000; // six tests of up to 400 cycles, reset, margin

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  ena;
   pc_ctrl_t              ctrl;
   logic [xlen-1:0]       imm;
   logic [reg_addr_w-1:0] rs1;
   logic [reg_addr_w-1:0] rs2;
   logic                  ld_hazard;
   logic [xlen-1:0]       fwd_data;
   logic                  wr_en;
   logic [reg_addr_w-1:0] wr_addr;
   logic [xlen-1:0]       wr_data;
   logic [xlen-1:0]       pc;
   logic                  jalr_stall;
   logic                  redirect;

   logic [xlen-1:0]       m_regs [reg_count]; // model state
   logic [xlen-1:0]       m_pc;
   logic                  m_pend;
   logic [reg_addr_w-1:0] sel_a;
   logic [reg_addr_w-1:0] sel_b;
   int                    errors = 0;
   int                    test_errs = 0;
   int                    pass_cnt = 0;
   int                    fail_cnt = 0;
   int                    cycles = 0;

   pc_unit_top dut_i (
      .clk(clk), .rst_n(rst_n), .ena(ena), .ctrl(ctrl), .imm(imm),
      .rs1(rs1), .rs2(rs2), .ld_hazard(ld_hazard), .fwd_data(fwd_data),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .pc(pc), .jalr_stall(jalr_stall), .redirect(redirect)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= max_cycles) begin
         $display("run stopped, no result after %0d cycles", cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   // funct3 branch conditions, unused codes never taken
   function automatic logic model_cond(input logic [2:0] op, input logic [xlen-1:0] a,
                                       input logic [xlen-1:0] b);
      case (op)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         3'd7: return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   function automatic cmp_op_e rand_op();
      case ($urandom_range(0, 5))
         0: return cmp_eq;
         1: return cmp_ne;
         2: return cmp_lt;
         3: return cmp_ge;
         4: return cmp_ltu;
         default: return cmp_geu;
      endcase
   endfunction

   function automatic logic [xlen-1:0] rand_word();
      return {$urandom, $urandom};
   endfunction

   function automatic logic [xlen-1:0] rand_imm();
      int v;
      v = int'($urandom_range(0, 4095)) - 2048;
      v = v & -2; // even offset
      return {{32{v[31]}}, v};
   endfunction

   task automatic idle_inputs();
      ena = 1'b1;
      ctrl = '0;
      imm = '0;
      rs1 = '0;
      rs2 = '0;
      ld_hazard = 1'b0;
      fwd_data = '0;
      wr_en = 1'b0;
      wr_addr = '0;
      wr_data = '0;
   endtask

   // one cycle from a falling edge to the next, checked against the model
   task automatic step();
      logic [xlen-1:0] exp_next;
      logic            exp_redir;
      logic            exp_stall;
      exp_next = m_pc + pc_step;
      exp_redir = 1'b0;
      exp_stall = 1'b0;
      if (ctrl.branch) begin
         if (model_cond(ctrl.cmp_op, m_regs[rs1], m_regs[rs2])) begin
            exp_next = m_pc + imm;
            exp_redir = 1'b1;
         end
      end else if (ctrl.jump && !ctrl.jalr) begin
         exp_next = m_pc + imm;
         exp_redir = 1'b1;
      end else if (ctrl.jump && ld_hazard) begin
         exp_stall = 1'b1;
      end else if (ctrl.jump) begin
         exp_next = (m_regs[rs1] + imm) & ~64'd1;
         exp_redir = 1'b1;
      end else if (m_pend) begin
         exp_next = (fwd_data + imm) & ~64'd1; // delayed jalr
         exp_redir = 1'b1;
      end else if (ctrl.ebreak) begin
         exp_next = reset_vector;
         exp_redir = 1'b1;
      end
      #10;
      if (redirect !== exp_redir) begin
         $display("Fail redirect: expected %h, got %h", exp_redir, redirect);
         errors++;
      end
      if (jalr_stall !== exp_stall) begin
         $display("Fail jalr_stall: expected %h, got %h", exp_stall, jalr_stall);
         errors++;
      end
      @(posedge clk);
      if (ena && !exp_stall) m_pc = exp_next;
      m_pend = exp_stall;
      if (wr_en && wr_addr != '0) m_regs[wr_addr] = wr_data;
      #40; // just before the falling edge
      if (pc !== m_pc) begin
         $display("Fail pc: expected %h, got %h", m_pc, pc);
         errors++;
      end
      @(negedge clk);
   endtask

   task automatic fill_regs();
      for (int i = 1; i < reg_count; i++) begin
         wr_en = 1'b1;
         wr_addr = reg_addr_w'(i);
         wr_data = rand_word();
         step();
      end
      wr_en = 1'b0;
   endtask

   task automatic end_test(input string name);
      idle_inputs();
      if (errors == test_errs) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: %0d errors", name, errors - test_errs);
      end
      test_errs = errors;
   endtask

   initial begin
      void'($urandom(32'he0ef_4f3d));
      idle_inputs();
      rst_n = 1'b0;
      m_pc = reset_vector;
      m_pend = 1'b0;
      for (int i = 0; i < reg_count; i++) m_regs[i] = '0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;

      if (pc !== reset_vector) begin
         $display("Fail pc: expected %h, got %h", reset_vector, pc);
         errors++;
      end
      if (jalr_stall !== 1'b0) begin
         $display("Fail jalr_stall: expected %h, got %h", 1'b0, jalr_stall);
         errors++;
      end
      for (int n = 0; n < 10; n++) step();
      ena = 1'b0; // freeze
      for (int n = 0; n < 5; n++) step();
      ena = 1'b1;
      for (int n = 0; n < 5; n++) step();
      end_test("reset_and_step");

      fill_regs();
      for (int n = 0; n < 300; n++) begin
         ctrl = '0;
         ctrl.branch = 1'b1;
         ctrl.cmp_op = rand_op();
         rs1 = reg_addr_w'($urandom_range(0, 31));
         rs2 = ($urandom_range(0, 3) == 0) ? rs1 : reg_addr_w'($urandom_range(0, 31));
         imm = rand_imm();
         step();
      end
      end_test("branches");

      fill_regs();
      for (int n = 0; n < 100; n++) begin
         ctrl = '0;
         ctrl.jump = 1'b1;
         ctrl.jalr = 1'($urandom_range(0, 1));
         rs1 = ($urandom_range(0, 7) == 0) ? '0 : reg_addr_w'($urandom_range(1, 31));
         imm = rand_imm();
         step();
      end
      end_test("jal_jalr");

      fill_regs();
      for (int n = 0; n < 40; n++) begin
         ctrl = '0;
         ctrl.jump = 1'b1;
         ctrl.jalr = 1'b1;
         rs1 = reg_addr_w'($urandom_range(0, 31));
         ld_hazard = 1'b1;
         imm = rand_imm();
         step();
         ctrl = '0; // imm stays for the delayed target
         ld_hazard = 1'b0;
         fwd_data = rand_word();
         step();
      end
      end_test("jalr_stall");

      for (int n = 0; n < 50; n++) begin
         ctrl = '0;
         ctrl.jump = 1'b1;
         imm = rand_word() & ~64'd1; // random far pc
         step();
         ctrl = '0;
         ctrl.ebreak = 1'b1;
         step();
      end
      end_test("ebreak");

      fill_regs();
      for (int n = 0; n < 40; n++) begin
         sel_a = reg_addr_w'($urandom_range(1, 31));
         sel_b = reg_addr_w'($urandom_range(0, 31));
         wr_en = 1'b1;
         wr_addr = sel_a;
         wr_data = ($urandom_range(0, 1) == 1) ? m_regs[sel_b] : rand_word();
         step();
         wr_en = 1'b0;
         ctrl = '0;
         ctrl.branch = 1'b1;
         ctrl.cmp_op = cmp_eq;
         rs1 = sel_a;
         rs2 = sel_b;
         imm = rand_imm();
         step();
         ctrl = '0;
      end
      for (int n = 0; n < 10; n++) begin
         sel_a = reg_addr_w'($urandom_range(1, 31));
         wr_en = 1'b1;
         wr_addr = sel_a;
         wr_data = '0;
         step();
         wr_addr = '0; // x0 write must be dropped
         wr_data = rand_word();
         step();
         wr_en = 1'b0;
         ctrl = '0;
         ctrl.branch = 1'b1;
         ctrl.cmp_op = cmp_eq;
         rs1 = '0;
         rs2 = sel_a;
         imm = rand_imm();
         step();
         ctrl = '0;
      end
      end_test("write_then_branch");

      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
common/pc_pkg.sv
hw/branch_cmp.sv
hw/next_pc_sel.sv
hw/pc_reg.sv
hw/gpr_file.sv
hw/pc_unit_top.sv
verif/tb_pc_unit.sv

//--- Makefile
TOOL     := verilator
TOP      := tb_pc_unit
FILELIST := list.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log
PASS     := TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
